// File: src/riscvPkg.sv
`default_nettype none

package riscvPkg;

    // --------------------
    // Opcodes
    localparam logic [6:0] opLoad   = 7'd3;
    localparam logic [6:0] opStore  = 7'd35;
    localparam logic [6:0] opRType  = 7'd51;
    localparam logic [6:0] opIType  = 7'd19;
    localparam logic [6:0] opBranch = 7'd99;
    localparam logic [6:0] opJal    = 7'd111;

    // --------------------
    // Datapath select codes
    localparam logic [2:0] aluAdd = 3'b000;
    localparam logic [2:0] aluSub = 3'b001;
    localparam logic [2:0] aluAnd = 3'b010;
    localparam logic [2:0] aluOr  = 3'b011;
    localparam logic [2:0] aluSlt = 3'b101;

    localparam logic [1:0] immI = 2'd0;
    localparam logic [1:0] immS = 2'd1;
    localparam logic [1:0] immB = 2'd2;
    localparam logic [1:0] immJ = 2'd3;

    localparam logic [1:0] resAlu = 2'd0;
    localparam logic [1:0] resMem = 2'd1;
    localparam logic [1:0] resPc4 = 2'd2;

    // --------------------
    // Instruction word, one view per encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rFmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iFmt;
        struct packed {
            logic [6:0] immHi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sFmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bFmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } jFmt;
    } instrT;

endpackage

`default_nettype wire

// File: src/mainDeco.sv
`timescale 1ns/1ps
`default_nettype none

module mainDeco (
    input  wire logic [6:0] op,
    output logic            branch,
    output logic            jump,
    output logic [1:0]      resSrc,
    output logic            memWrite,
    output logic            aluSrc,
    output logic [1:0]      immSrc,
    output logic            regWrite,
    output logic [1:0]      aluOp
);

    import riscvPkg::*;

    always_comb
    begin
        branch   = 1'b0; // All inactive unless decoded.
        jump     = 1'b0;
        resSrc   = resAlu;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        immSrc   = immI;
        regWrite = 1'b0;
        aluOp    = 2'b00;
        case (op)
            opLoad:
            begin
                resSrc   = resMem;
                aluSrc   = 1'b1;
                immSrc   = immI;
                regWrite = 1'b1;
            end
            opStore:
            begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = immS;
            end
            opRType:
            begin
                regWrite = 1'b1;
                aluOp    = 2'b10;
            end
            opIType:
            begin
                aluSrc   = 1'b1;
                immSrc   = immI;
                regWrite = 1'b1;
                aluOp    = 2'b10;
            end
            opBranch:
            begin
                branch = 1'b1;
                immSrc = immB;
                aluOp  = 2'b01; // Compare by subtraction.
            end
            opJal:
            begin
                jump     = 1'b1;
                resSrc   = resPc4; // Link value.
                immSrc   = immJ;
                regWrite = 1'b1;
            end
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/aluDeco.sv
`timescale 1ns/1ps
`default_nettype none

module aluDeco (
    input  wire logic [1:0] aluOp,
    input  wire logic [2:0] funct3,
    input  wire logic       funct7b5,
    input  wire logic       opb5,
    output logic [2:0]      aluControl
);

    import riscvPkg::*;

    logic rTypeSub;

    assign rTypeSub = funct7b5 & opb5; // Only register form has sub.

    always_comb
    begin
        case (aluOp)
            2'b00: aluControl = aluAdd; // Address calculation.
            2'b01: aluControl = aluSub; // Branch compare.
            2'b10:
            begin
                case (funct3)
                    3'b000:  aluControl = rTypeSub ? aluSub : aluAdd;
                    3'b010:  aluControl = aluSlt;
                    3'b110:  aluControl = aluOr;
                    3'b111:  aluControl = aluAnd;
                    default: aluControl = aluAdd;
                endcase
            end
            default: aluControl = aluAdd;
        endcase
    end

    always_comb
    begin
        assert (aluOp != 2'b11)
            else $error("aluDeco: undefined aluOp 3");
    end

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic        clk,
    input  wire logic        we,
    input  wire logic [4:0]  ra1,
    input  wire logic [4:0]  ra2,
    input  wire logic [4:0]  wa,
    input  wire logic [31:0] wd,
    output logic [31:0]      rd1,
    output logic [31:0]      rd2
);

    logic [31:0] regs [1:31]; // x0 has no storage.

    always_ff @(posedge clk)
    begin
        if (we && (wa != 5'd0))
        begin
            regs[wa] <= wd;
        end
    end

    always_comb
    begin
        rd1 = 32'd0;
        rd2 = 32'd0;
        if (ra1 != 5'd0)
        begin
            rd1 = regs[ra1];
        end
        if (ra2 != 5'd0)
        begin
            rd2 = regs[ra2];
        end
    end

endmodule

`default_nettype wire

// File: src/dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  wire logic          clk,
    input  wire logic          arstN,
    input  wire riscvPkg::instrT instr,
    input  wire logic          pcSrc,
    input  wire logic [1:0]    resSrc,
    input  wire logic          aluSrc,
    input  wire logic [1:0]    immSrc,
    input  wire logic [2:0]    aluControl,
    input  wire logic          regWrite,
    input  wire logic [31:0]   readData,
    output logic [31:0]        pc,
    output logic [31:0]        aluResult,
    output logic [31:0]        writeData,
    output logic               zero
);

    import riscvPkg::*;

    logic [31:0] pcNext;
    logic [31:0] pcPlus4;
    logic [31:0] pcTarget;
    logic [31:0] immExt;
    logic [31:0] srcA;
    logic [31:0] srcB;
    logic [31:0] result;

    // --------------------
    // Program counter
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            pc <= resetPc;
        end
        else
        begin
            pc <= pcNext;
        end
    end

    assign pcPlus4  = pc + 32'd4;
    assign pcTarget = pc + immExt; // Branch and jal target.
    assign pcNext   = pcSrc ? pcTarget : pcPlus4;

    always_comb
    begin
        case (immSrc)
            immI: immExt = {{20{instr.iFmt.imm[11]}}, instr.iFmt.imm};
            immS: immExt = {{20{instr.sFmt.immHi[6]}}, instr.sFmt.immHi, instr.sFmt.immLo};
            immB: immExt = {{20{instr.bFmt.imm12}}, instr.bFmt.imm11, instr.bFmt.imm10to5,
                            instr.bFmt.imm4to1, 1'b0};
            default: immExt = {{12{instr.jFmt.imm20}}, instr.jFmt.imm19to12,
                               instr.jFmt.imm11, instr.jFmt.imm10to1, 1'b0};
        endcase
    end

    regFile regs (
        .clk (clk),
        .we  (regWrite),
        .ra1 (instr.rFmt.rs1),
        .ra2 (instr.rFmt.rs2),
        .wa  (instr.rFmt.rd),
        .wd  (result),
        .rd1 (srcA),
        .rd2 (writeData)
    );

    // --------------------
    // ALU and write-back
    assign srcB = aluSrc ? immExt : writeData;

    always_comb
    begin
        case (aluControl)
            aluAdd:  aluResult = srcA + srcB;
            aluSub:  aluResult = srcA - srcB;
            aluAnd:  aluResult = srcA & srcB;
            aluOr:   aluResult = srcA | srcB;
            aluSlt:  aluResult = {31'd0, $signed(srcA) < $signed(srcB)};
            default: aluResult = 32'd0;
        endcase
    end

    assign zero = (aluResult == 32'd0);

    always_comb
    begin
        case (resSrc)
            resMem:  result = readData;
            resPc4:  result = pcPlus4;
            default: result = aluResult;
        endcase
    end

    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("dataPath: pc %h not word aligned", pc);

endmodule

`default_nettype wire

// File: src/riscvSingle.sv
`timescale 1ns/1ps
`default_nettype none

module riscvSingle #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  wire logic        clk,
    input  wire logic        arstN,
    output logic [31:0]      pc,
    input  wire logic [31:0] instr,
    output logic [31:0]      memAddr,
    output logic [31:0]      memWriteData,
    output logic             memWrite,
    input  wire logic [31:0] memReadData
);

    import riscvPkg::*;

    instrT       instrWord;
    logic        branch;
    logic        jump;
    logic        zero;
    logic        pcSrc;
    logic        aluSrc;
    logic        regWrite;
    logic [1:0]  resSrc;
    logic [1:0]  immSrc;
    logic [1:0]  aluOp;
    logic [2:0]  aluControl;

    assign instrWord = instrT'(instr);

    mainDeco mDeco (
        .op       (instrWord.rFmt.opcode),
        .branch   (branch),
        .jump     (jump),
        .resSrc   (resSrc),
        .memWrite (memWrite),
        .aluSrc   (aluSrc),
        .immSrc   (immSrc),
        .regWrite (regWrite),
        .aluOp    (aluOp)
    );

    aluDeco aDeco (
        .aluOp      (aluOp),
        .funct3     (instrWord.rFmt.funct3),
        .funct7b5   (instrWord.rFmt.funct7[5]),
        .opb5       (instrWord.rFmt.opcode[5]),
        .aluControl (aluControl)
    );

    assign pcSrc = jump | (branch & zero); // Taken beq or jal.

    dataPath #(
        .resetPc (resetPc)
    ) dPath (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instrWord),
        .pcSrc      (pcSrc),
        .resSrc     (resSrc),
        .aluSrc     (aluSrc),
        .immSrc     (immSrc),
        .aluControl (aluControl),
        .regWrite   (regWrite),
        .readData   (memReadData),
        .pc         (pc),
        .aluResult  (memAddr),
        .writeData  (memWriteData),
        .zero       (zero)
    );

endmodule

`default_nettype wire

// File: verif/riscvSingleTb.sv
`timescale 1ns/1ps
`default_nettype none

module riscvSingleTb;

    localparam int         maxCycles    = 1000;
    localparam logic [6:0] branchOpcode = 7'h63;
    localparam logic [6:0] jalOpcode    = 7'h6F;

    logic        clk;
    logic        arstN;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] memAddr;
    logic [31:0] memWriteData;
    logic        memWrite;
    logic [31:0] memReadData;

    logic [31:0] progMem [logic [31:0]]; // Sparse program image.
    logic [31:0] dataMem [0:63];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    int          runCycles;
    int          storeIdx;
    int          errors;
    int          checks;
    bit          traceOk;

    riscvSingle #(
        .resetPc (32'h0000_0000)
    ) dut (
        .clk          (clk),
        .arstN        (arstN),
        .pc           (pc),
        .instr        (instr),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .memReadData  (memReadData)
    );

    always #4 clk = ~clk;

    // --------------------
    // Trace loading
    task automatic readTrace();
        int          fd;
        int          got;
        string       line;
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        traceOk   = 1'b0;
        runCycles = 0;
        fd = $fopen("verif/riscvSingleTrace.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the trace file verif/riscvSingleTrace.txt");
            errors++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                got  = $fgets(line, fd);
                kind = line.getc(0);
                case (kind)
                    "P", "S":
                    begin
                        got = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
                        if (got != 2)
                        begin
                            $display("Malformed trace line: %s", line);
                            errors++;
                        end
                        else if (kind == "P")
                        begin
                            progMem[a] = b;
                        end
                        else
                        begin
                            expAddr.push_back(a);
                            expData.push_back(b);
                        end
                    end
                    "C": got = $sscanf(line.substr(1, line.len() - 1), "%d", runCycles);
                    default:
                    begin
                    end
                endcase
            end
            $fclose(fd);
            if (progMem.num() == 0 || expAddr.size() == 0 || runCycles <= 0 ||
                runCycles > maxCycles)
            begin
                $display("Trace file is incomplete or its run length is out of range");
                errors++;
            end
            else
            begin
                traceOk = 1'b1;
            end
        end
    endtask

    // --------------------
    // Memory models and checks
    task automatic driveFetch();
        if (progMem.exists(pc))
        begin
            instr = progMem[pc];
        end
        else
        begin
            $display("pc %h fetched outside the loaded program", pc);
            errors++;
            instr = 32'h0; // Decodes as a no-op.
        end
    endtask

    task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
        if (storeIdx >= expAddr.size())
        begin
            $display("Unexpected store to address %h after the final expected store", addr);
            errors++;
        end
        else
        begin
            checks++;
            if (addr != expAddr[storeIdx])
            begin
                $display("Mismatch memAddr (store %0d): got %h, expected %h",
                         storeIdx, addr, expAddr[storeIdx]);
                errors++;
            end
            if (data != expData[storeIdx])
            begin
                $display("Mismatch memWriteData (store %0d): got %h, expected %h",
                         storeIdx, data, expData[storeIdx]);
                errors++;
            end
            storeIdx++;
        end
    endtask

    task automatic runProgram();
        int          cycle;
        logic [31:0] prevPc;
        logic        prevCtrl;
        logic        sWrite;
        logic [31:0] sAddr;
        logic [31:0] sData;
        prevPc   = 32'h0;
        prevCtrl = 1'b0;
        for (cycle = 0; cycle < runCycles; cycle++)
        begin
            driveFetch(); // On the falling edge.
            #1;
            memReadData = dataMem[memAddr[7:2]];
            #2;
            checks++;
            if (cycle == 0 && pc != 32'h0)
            begin
                $display("Mismatch pc after reset: got %h, expected %h", pc, 32'h0);
                errors++;
            end
            else if (cycle > 0 && !prevCtrl && pc != prevPc + 32'd4)
            begin
                $display("Mismatch pc: got %h, expected %h", pc, prevPc + 32'd4);
                errors++;
            end
            prevPc   = pc;
            prevCtrl = (instr[6:0] == branchOpcode) || (instr[6:0] == jalOpcode);
            sWrite   = memWrite;
            sAddr    = memAddr;
            sData    = memWriteData;
            @(posedge clk);
            if (sWrite)
            begin
                dataMem[sAddr[7:2]] = sData;
                checkStore(sAddr, sData);
            end
            @(negedge clk);
        end
    endtask

    initial
    begin
        int i;
        void'($urandom(77));
        clk         = 1'b0;
        arstN       = 1'b0;
        instr       = 32'h0;
        memReadData = 32'h0;
        errors      = 0;
        checks      = 0;
        storeIdx    = 0;
        for (i = 0; i < 64; i++)
        begin
            dataMem[i] = $urandom;
        end
        readTrace();
        if (traceOk)
        begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            checks++;
            if (pc != 32'h0)
            begin
                $display("Mismatch pc in reset: got %h, expected %h", pc, 32'h0);
                errors++;
            end
            if (memWrite)
            begin
                $display("Mismatch memWrite in reset: got %h, expected %h", memWrite, 1'b0);
                errors++;
            end
            arstN = 1'b1;
            runProgram();
            if (storeIdx < expAddr.size())
            begin
                $display("Timed out after %0d cycles with %0d of %0d expected stores seen",
                         runCycles, storeIdx, expAddr.size());
                errors++;
            end
        end
        $display("Checks: %0d, stores: %0d of %0d, errors: %0d",
                 checks, storeIdx, expAddr.size(), errors);
        if (errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/riscvSingleTrace.txt
# P lines hold a hex address and instruction, S lines an expected store address and data
# The C line holds the number of cycles to run, in decimal
P 00000000 00500093 # addi x1, x0, 5
P 00000004 00C00113 # addi x2, x0, 12
P 00000008 002081B3 # add  x3, x1, x2
P 0000000C 40110233 # sub  x4, x2, x1
P 00000010 0020F2B3 # and  x5, x1, x2
P 00000014 0020E333 # or   x6, x1, x2
P 00000018 0020A3B3 # slt  x7, x1, x2
P 0000001C 04302023 # sw   x3, 64(x0)
P 00000020 04402223 # sw   x4, 68(x0)
P 00000024 04502423 # sw   x5, 72(x0)
P 00000028 04602623 # sw   x6, 76(x0)
P 0000002C 04702823 # sw   x7, 80(x0)
P 00000030 00617413 # andi x8, x2, 6
P 00000034 0300E493 # ori  x9, x1, 0x30
P 00000038 0060A513 # slti x10, x1, 6
P 0000003C 04802A23 # sw   x8, 84(x0)
P 00000040 04902C23 # sw   x9, 88(x0)
P 00000044 04A02E23 # sw   x10, 92(x0)
P 00000048 04002583 # lw   x11, 64(x0)
P 0000004C 06B02023 # sw   x11, 96(x0)
P 00000050 00900013 # addi x0, x0, 9
P 00000054 06002223 # sw   x0, 100(x0)
P 00000058 00208463 # beq  x1, x2, +8 (not taken)
P 0000005C 00100613 # addi x12, x0, 1
P 00000060 00108463 # beq  x1, x1, +8 (taken)
P 00000064 00200613 # addi x12, x0, 2 (skipped)
P 00000068 06C02423 # sw   x12, 104(x0)
P 0000006C 008006EF # jal  x13, +8
P 00000070 00300613 # addi x12, x0, 3 (skipped)
P 00000074 06D02623 # sw   x13, 108(x0)
P 00000078 06C02823 # sw   x12, 112(x0)
P 0000007C 0000006F # jal  x0, 0 (spin)
S 00000040 00000011
S 00000044 00000007
S 00000048 00000004
S 0000004C 0000000D
S 00000050 00000001
S 00000054 00000004
S 00000058 00000035
S 0000005C 00000001
S 00000060 00000011
S 00000064 00000000
S 00000068 00000001
S 0000006C 00000070
S 00000070 00000001
C 40

// File: riscvSingle.f
src/riscvPkg.sv
src/mainDeco.sv
src/aluDeco.sv
src/regFile.sv
src/dataPath.sv
src/riscvSingle.sv
verif/riscvSingleTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f riscvSingle.f --top-module riscvSingleTb -Mdir obj_dir
	./obj_dir/VriscvSingleTb | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
